// File: exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Data path and address width
`define XLEN 32

// Architectural register index width, 32 registers
`define REG_ADDR_W 5

// Word address width of the data memory, 1024 words
`define DMEM_ADDR_W 10

`endif

// File: logic/isa_pkg.sv
package isa_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,          // Signed less than
    alu_sltu,         // Unsigned less than
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_src2     // LU12I style, second operand straight through
  } alu_op_e;

  typedef enum logic [1:0] {
    src_reg,
    src_pc,
    src_imm,
    src_four          // Link value pc + 4
  } src_sel_e;

  typedef enum logic [2:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_jump           // Always taken
  } br_type_e;

  // Load codes sit between the store codes
  typedef enum logic [2:0] {
    mem_none  = 3'd0,
    mem_st_w  = 3'd1,
    mem_ld_w  = 3'd2,
    mem_ld_b  = 3'd3,
    mem_ld_bu = 3'd4,
    mem_ld_h  = 3'd5,
    mem_st_b  = 3'd6,
    mem_st_h  = 3'd7
  } mem_type_e;

  function automatic logic is_store(mem_type_e t);
    return t inside {mem_st_w, mem_st_b, mem_st_h};
  endfunction

  function automatic logic is_load(mem_type_e t);
    return t inside {mem_ld_w, mem_ld_b, mem_ld_bu, mem_ld_h};
  endfunction

endpackage

// File: logic/pipe_pkg.sv
`include "exec_params.svh"

package pipe_pkg;

  // One issued instruction as it enters EX
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       imm;          // Already sign extended by decode
    logic [`XLEN-1:0]       rdata1;       // Register file values, before forwarding
    logic [`XLEN-1:0]       rdata2;
    logic [`REG_ADDR_W-1:0] raddr1;
    logic [`REG_ADDR_W-1:0] raddr2;
    isa_pkg::src_sel_e      src1_sel;
    isa_pkg::src_sel_e      src2_sel;
    isa_pkg::alu_op_e       alu_op;
    isa_pkg::br_type_e      br_type;
    logic                   br_pred;      // 1 means predicted taken
    logic                   rf_we;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    isa_pkg::mem_type_e     mem_type;
  } issue_slot_t;

  // Register write leaving MEM or WB
  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] waddr;
    logic [`XLEN-1:0]       wdata;
  } wb_slot_t;

  // Byte enabled write into the data memory
  typedef struct packed {
    logic [3:0]              byte_en;
    logic [`DMEM_ADDR_W-1:0] addr;       // Word address
    logic [`XLEN-1:0]        wdata;      // Already shifted to its byte lanes
  } store_req_t;

endpackage

// File: logic/operand_forward.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module operand_forward (
  input  pipe_pkg::issue_slot_t slot_a,
  input  pipe_pkg::issue_slot_t slot_b,
  input  pipe_pkg::wb_slot_t    mem_a,
  input  pipe_pkg::wb_slot_t    mem_b,
  input  pipe_pkg::wb_slot_t    wb_a,
  input  pipe_pkg::wb_slot_t    wb_b,
  output logic [`XLEN-1:0]      opnd_a1,
  output logic [`XLEN-1:0]      opnd_a2,
  output logic [`XLEN-1:0]      opnd_b1,
  output logic [`XLEN-1:0]      opnd_b2
);

  // Youngest producer wins, lane b is younger than lane a within a stage
  function automatic logic [`XLEN-1:0] fwd_value(
    input logic [`REG_ADDR_W-1:0] raddr,
    input logic [`XLEN-1:0]       rdata,
    input pipe_pkg::wb_slot_t     m_a,
    input pipe_pkg::wb_slot_t     m_b,
    input pipe_pkg::wb_slot_t     w_a,
    input pipe_pkg::wb_slot_t     w_b
  );
    if (raddr == '0)
      return '0;                                   // r0 is hardwired zero
    if (m_b.we && m_b.waddr == raddr)
      return m_b.wdata;
    if (m_a.we && m_a.waddr == raddr)
      return m_a.wdata;
    if (w_b.we && w_b.waddr == raddr)
      return w_b.wdata;
    if (w_a.we && w_a.waddr == raddr)
      return w_a.wdata;
    return rdata;
  endfunction

  assign opnd_a1 = fwd_value(slot_a.raddr1, slot_a.rdata1, mem_a, mem_b, wb_a, wb_b);
  assign opnd_a2 = fwd_value(slot_a.raddr2, slot_a.rdata2, mem_a, mem_b, wb_a, wb_b);
  assign opnd_b1 = fwd_value(slot_b.raddr1, slot_b.rdata1, mem_a, mem_b, wb_a, wb_b);
  assign opnd_b2 = fwd_value(slot_b.raddr2, slot_b.rdata2, mem_a, mem_b, wb_a, wb_b);

endmodule

// File: logic/dual_alu.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module dual_alu (
  input  pipe_pkg::issue_slot_t slot_a,
  input  pipe_pkg::issue_slot_t slot_b,
  input  logic [`XLEN-1:0]      opnd_a1,
  input  logic [`XLEN-1:0]      opnd_a2,
  input  logic [`XLEN-1:0]      opnd_b1,
  input  logic [`XLEN-1:0]      opnd_b2,
  output logic [`XLEN-1:0]      alu_a,
  output logic [`XLEN-1:0]      alu_b
);

  logic [`XLEN-1:0] x_a;
  logic [`XLEN-1:0] y_a;
  logic [`XLEN-1:0] x_b;
  logic [`XLEN-1:0] y_b;

  function automatic logic [`XLEN-1:0] pick_src(
    input isa_pkg::src_sel_e sel,
    input logic [`XLEN-1:0]  opnd,
    input logic [`XLEN-1:0]  pc,
    input logic [`XLEN-1:0]  imm
  );
    case (sel)
      isa_pkg::src_reg: return opnd;
      isa_pkg::src_pc:  return pc;
      isa_pkg::src_imm: return imm;
      default:          return `XLEN'd4;   // Link address offset
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] alu_calc(
    input isa_pkg::alu_op_e op,
    input logic [`XLEN-1:0] x,
    input logic [`XLEN-1:0] y
  );
    case (op)
      isa_pkg::alu_add:  return x + y;
      isa_pkg::alu_sub:  return x - y;
      isa_pkg::alu_and:  return x & y;
      isa_pkg::alu_or:   return x | y;
      isa_pkg::alu_xor:  return x ^ y;
      isa_pkg::alu_slt:  return {{(`XLEN-1){1'b0}}, $signed(x) < $signed(y)};
      isa_pkg::alu_sltu: return {{(`XLEN-1){1'b0}}, x < y};
      isa_pkg::alu_sll:  return x << y[4:0];
      isa_pkg::alu_srl:  return x >> y[4:0];
      isa_pkg::alu_sra:  return $signed(x) >>> y[4:0];
      default:           return y;           // pass_src2
    endcase
  endfunction

  assign x_a = pick_src(slot_a.src1_sel, opnd_a1, slot_a.pc, slot_a.imm);
  assign y_a = pick_src(slot_a.src2_sel, opnd_a2, slot_a.pc, slot_a.imm);
  assign x_b = pick_src(slot_b.src1_sel, opnd_b1, slot_b.pc, slot_b.imm);
  assign y_b = pick_src(slot_b.src2_sel, opnd_b2, slot_b.pc, slot_b.imm);

  assign alu_a = alu_calc(slot_a.alu_op, x_a, y_a);
  assign alu_b = alu_calc(slot_b.alu_op, x_b, y_b);

endmodule

// File: logic/branch_resolve.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module branch_resolve (
  input  pipe_pkg::issue_slot_t slot_a,
  input  pipe_pkg::issue_slot_t slot_b,
  input  logic [`XLEN-1:0]      opnd_a1,
  input  logic [`XLEN-1:0]      opnd_a2,
  input  logic [`XLEN-1:0]      opnd_b1,
  input  logic [`XLEN-1:0]      opnd_b2,
  output logic                  br_a,
  output logic                  redirect,
  output logic [`XLEN-1:0]      redirect_pc
);

  logic             taken_a;
  logic             taken_b;
  logic             mis_a;
  logic             mis_b;
  logic [`XLEN-1:0] tgt_a;
  logic [`XLEN-1:0] tgt_b;

  function automatic logic br_taken(
    input isa_pkg::br_type_e t,
    input logic [`XLEN-1:0]  x,
    input logic [`XLEN-1:0]  y
  );
    case (t)
      isa_pkg::br_beq:  return x == y;
      isa_pkg::br_bne:  return x != y;
      isa_pkg::br_blt:  return $signed(x) < $signed(y);
      isa_pkg::br_bge:  return $signed(x) >= $signed(y);
      isa_pkg::br_bltu: return x < y;
      isa_pkg::br_bgeu: return x >= y;
      isa_pkg::br_jump: return 1'b1;
      default:          return 1'b0;
    endcase
  endfunction

  assign taken_a = br_taken(slot_a.br_type, opnd_a1, opnd_a2);
  assign taken_b = br_taken(slot_b.br_type, opnd_b1, opnd_b2);

  // Front end does not know the target, so a taken branch always redirects
  assign mis_a = taken_a | slot_a.br_pred;
  assign mis_b = taken_b | slot_b.br_pred;

  assign tgt_a = taken_a ? slot_a.pc + slot_a.imm : slot_a.pc + `XLEN'd4;
  assign tgt_b = taken_b ? slot_b.pc + slot_b.imm : slot_b.pc + `XLEN'd4;

  assign br_a        = mis_a;
  assign redirect    = mis_a | mis_b;
  assign redirect_pc = mis_a ? tgt_a : tgt_b;   // Older lane first

endmodule

// File: logic/store_align.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module store_align (
  input  isa_pkg::mem_type_e   mem_type_a,
  input  isa_pkg::mem_type_e   mem_type_b,
  input  logic [`XLEN-1:0]     alu_a,
  input  logic [`XLEN-1:0]     alu_b,
  input  logic [`XLEN-1:0]     store_data_a,
  input  logic [`XLEN-1:0]     store_data_b,
  input  logic                 br_a,
  output pipe_pkg::store_req_t store,
  output logic [`DMEM_ADDR_W-1:0] rd_addr
);

  logic               st_a;
  logic               st_b;
  isa_pkg::mem_type_e st_type;
  logic [`XLEN-1:0]   st_addr;
  logic [`XLEN-1:0]   st_data;

  assign st_a    = isa_pkg::is_store(mem_type_a);
  assign st_b    = isa_pkg::is_store(mem_type_b) && !br_a;   // Squashed by lane a
  assign st_type = st_a ? mem_type_a : mem_type_b;           // At most one store per cycle
  assign st_addr = st_a ? alu_a : alu_b;
  assign st_data = st_a ? store_data_a : store_data_b;

  always_comb begin
    store.addr    = st_addr[`DMEM_ADDR_W+1:2];
    store.byte_en = 4'b0000;
    store.wdata   = st_data;
    if (st_a || st_b) begin
      case (st_type)
        isa_pkg::mem_st_b: begin
          store.byte_en = 4'b0001 << st_addr[1:0];           // Little endian lane
          store.wdata   = st_data << {st_addr[1:0], 3'b000};
        end
        isa_pkg::mem_st_h: begin
          store.byte_en = st_addr[1] ? 4'b1100 : 4'b0011;
          store.wdata   = st_addr[1] ? st_data << 16 : st_data;
        end
        isa_pkg::mem_st_w: store.byte_en = 4'b1111;
        default: store.byte_en = 4'b0000;
      endcase
    end
  end

  // Only lane b loads
  assign rd_addr = alu_b[`DMEM_ADDR_W+1:2];

endmodule

// File: logic/data_memory.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module data_memory (
  input  logic                    clk,
  input  pipe_pkg::store_req_t    store,
  input  logic [`DMEM_ADDR_W-1:0] rd_addr,
  output logic [`XLEN-1:0]        rd_data
);

  localparam int DEPTH = 1 << `DMEM_ADDR_W;

  logic [`XLEN-1:0] mem [0:DEPTH-1];

  // Byte lane writes
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (store.byte_en[i])
        mem[store.addr][8*i +: 8] <= store.wdata[8*i +: 8];
    end
  end

  // Registered read, old data on a same cycle write
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: logic/exec_pipe_regs.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module exec_pipe_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  pipe_pkg::issue_slot_t slot_a,
  input  pipe_pkg::issue_slot_t slot_b,
  input  logic                  br_a,
  input  logic [`XLEN-1:0]      alu_a,
  input  logic [`XLEN-1:0]      alu_b,
  input  logic [`XLEN-1:0]      rd_data,
  output pipe_pkg::wb_slot_t    mem_a,
  output pipe_pkg::wb_slot_t    mem_b,
  output pipe_pkg::wb_slot_t    wb_a,
  output pipe_pkg::wb_slot_t    wb_b
);

  isa_pkg::mem_type_e ld_type;      // Lane b access kind in MEM
  logic [1:0]         ld_offset;    // Byte offset within the word
  logic [7:0]         ld_byte;
  logic [15:0]        ld_half;
  logic [`XLEN-1:0]   ld_value;

  always_ff @(posedge clk) begin
    mem_a.waddr <= slot_a.rf_waddr;
    mem_a.wdata <= alu_a;
    mem_b.waddr <= slot_b.rf_waddr;
    mem_b.wdata <= alu_b;             // Loads overwrite this in MEM
    ld_offset   <= alu_b[1:0];
    wb_a.waddr  <= mem_a.waddr;
    wb_a.wdata  <= mem_a.wdata;
    wb_b.waddr  <= mem_b.waddr;
    wb_b.wdata  <= isa_pkg::is_load(ld_type) ? ld_value : mem_b.wdata;
    if (reset) begin
      mem_a.we <= 1'b0;
      mem_b.we <= 1'b0;
      wb_a.we  <= 1'b0;
      wb_b.we  <= 1'b0;
      ld_type  <= isa_pkg::mem_none;
    end else begin
      mem_a.we <= slot_a.rf_we;
      mem_b.we <= slot_b.rf_we && !br_a;   // Younger lane dies on lane a redirect
      wb_a.we  <= mem_a.we;
      wb_b.we  <= mem_b.we;
      ld_type  <= slot_b.mem_type;
    end
  end

  assign ld_byte = rd_data[{ld_offset, 3'b000} +: 8];
  assign ld_half = ld_offset[1] ? rd_data[31:16] : rd_data[15:0];

  always_comb begin
    case (ld_type)
      isa_pkg::mem_ld_b:  ld_value = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
      isa_pkg::mem_ld_bu: ld_value = {{(`XLEN-8){1'b0}}, ld_byte};
      isa_pkg::mem_ld_h:  ld_value = {{(`XLEN-16){ld_half[15]}}, ld_half};
      default:            ld_value = rd_data;             // ld_w
    endcase
  end

endmodule

// File: logic/ex_mem_wb.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module ex_mem_wb (
  input  logic                  clk,
  input  logic                  reset,
  input  pipe_pkg::issue_slot_t slot_a,
  input  pipe_pkg::issue_slot_t slot_b,
  output pipe_pkg::wb_slot_t    wb_a,
  output pipe_pkg::wb_slot_t    wb_b,
  output logic                  redirect,
  output logic [`XLEN-1:0]      redirect_pc
);

  logic [`XLEN-1:0]        opnd_a1;     // Forwarded source operands
  logic [`XLEN-1:0]        opnd_a2;
  logic [`XLEN-1:0]        opnd_b1;
  logic [`XLEN-1:0]        opnd_b2;
  logic [`XLEN-1:0]        alu_a;
  logic [`XLEN-1:0]        alu_b;
  logic                    br_a;
  pipe_pkg::store_req_t    store;
  logic [`DMEM_ADDR_W-1:0] rd_addr;
  logic [`XLEN-1:0]        rd_data;
  pipe_pkg::wb_slot_t      mem_a;       // MEM stage results
  pipe_pkg::wb_slot_t      mem_b;

  operand_forward u_forward (
    .slot_a (slot_a),
    .slot_b (slot_b),
    .mem_a  (mem_a),
    .mem_b  (mem_b),
    .wb_a   (wb_a),
    .wb_b   (wb_b),
    .opnd_a1(opnd_a1),
    .opnd_a2(opnd_a2),
    .opnd_b1(opnd_b1),
    .opnd_b2(opnd_b2)
  );

  dual_alu u_alu (
    .slot_a (slot_a),
    .slot_b (slot_b),
    .opnd_a1(opnd_a1),
    .opnd_a2(opnd_a2),
    .opnd_b1(opnd_b1),
    .opnd_b2(opnd_b2),
    .alu_a  (alu_a),
    .alu_b  (alu_b)
  );

  branch_resolve u_branch (
    .slot_a     (slot_a),
    .slot_b     (slot_b),
    .opnd_a1    (opnd_a1),
    .opnd_a2    (opnd_a2),
    .opnd_b1    (opnd_b1),
    .opnd_b2    (opnd_b2),
    .br_a       (br_a),
    .redirect   (redirect),
    .redirect_pc(redirect_pc)
  );

  store_align u_store (
    .mem_type_a  (slot_a.mem_type),
    .mem_type_b  (slot_b.mem_type),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .store_data_a(opnd_a2),
    .store_data_b(opnd_b2),
    .br_a        (br_a),
    .store       (store),
    .rd_addr     (rd_addr)
  );

  data_memory u_dmem (
    .clk    (clk),
    .store  (store),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  exec_pipe_regs u_pipe (
    .clk    (clk),
    .reset  (reset),
    .slot_a (slot_a),
    .slot_b (slot_b),
    .br_a   (br_a),
    .alu_a  (alu_a),
    .alu_b  (alu_b),
    .rd_data(rd_data),
    .mem_a  (mem_a),
    .mem_b  (mem_b),
    .wb_a   (wb_a),
    .wb_b   (wb_b)
  );

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;   // 40 ns period

endmodule

// File: sim/tb_ex_mem_wb.sv
`timescale 1ns/10ps

module tb_ex_mem_wb;

  logic                  clk;
  logic                  reset;
  pipe_pkg::issue_slot_t slot_a;
  pipe_pkg::issue_slot_t slot_b;
  pipe_pkg::wb_slot_t    wb_a;
  pipe_pkg::wb_slot_t    wb_b;
  logic                  redirect;
  logic [31:0]           redirect_pc;

  integer             seed;
  int                 errors;
  logic [31:0]        arch_rf [0:31];   // Architectural state
  logic [31:0]        stale_rf [0:31];  // What the register file shows at issue
  logic [7:0]         mem_model [0:63];
  logic               load_prev;
  logic [4:0]         load_rd;
  pipe_pkg::wb_slot_t hist_a [$];
  pipe_pkg::wb_slot_t hist_b [$];
  pipe_pkg::wb_slot_t exp_a [$];
  pipe_pkg::wb_slot_t exp_b [$];

  clock_gen u_clk (.clk(clk));

  ex_mem_wb dut (
    .clk        (clk),
    .reset      (reset),
    .slot_a     (slot_a),
    .slot_b     (slot_b),
    .wb_a       (wb_a),
    .wb_b       (wb_b),
    .redirect   (redirect),
    .redirect_pc(redirect_pc)
  );

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] pick_operand(isa_pkg::src_sel_e sel, logic [31:0] r,
                                               logic [31:0] pc, logic [31:0] imm);
    case (sel)
      isa_pkg::src_reg: return r;
      isa_pkg::src_pc:  return pc;
      isa_pkg::src_imm: return imm;
      default:          return 32'd4;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(isa_pkg::alu_op_e op, logic [31:0] x, logic [31:0] y);
    case (op)
      isa_pkg::alu_add:  return x + y;
      isa_pkg::alu_sub:  return x - y;
      isa_pkg::alu_and:  return x & y;
      isa_pkg::alu_or:   return x | y;
      isa_pkg::alu_xor:  return x ^ y;
      isa_pkg::alu_slt:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      isa_pkg::alu_sltu: return (x < y) ? 32'd1 : 32'd0;
      isa_pkg::alu_sll:  return x << y[4:0];
      isa_pkg::alu_srl:  return x >> y[4:0];
      isa_pkg::alu_sra:  return $unsigned($signed(x) >>> y[4:0]);
      default:           return y;
    endcase
  endfunction

  function automatic logic taken_model(isa_pkg::br_type_e t, logic [31:0] x, logic [31:0] y);
    case (t)
      isa_pkg::br_beq:  return x == y;
      isa_pkg::br_bne:  return x != y;
      isa_pkg::br_blt:  return $signed(x) < $signed(y);
      isa_pkg::br_bge:  return $signed(x) >= $signed(y);
      isa_pkg::br_bltu: return x < y;
      isa_pkg::br_bgeu: return x >= y;
      isa_pkg::br_jump: return 1'b1;
      default:          return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (expv !== actv) begin
      errors++;
      $display("ERR %s expected %h got %h at %0t", name, expv, actv, $time);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic compare_wb(input string name, input pipe_pkg::wb_slot_t e,
                            input pipe_pkg::wb_slot_t g);
    check_value({name, ".we"}, e.we, g.we);
    if (e.we) begin
      check_value({name, ".waddr"}, e.waddr, g.waddr);
      check_value({name, ".wdata"}, e.wdata, g.wdata);
    end
  endtask

  task automatic gen_slot(output pipe_pkg::issue_slot_t s);
    s          = '0;
    s.pc       = {$random(seed)} & 32'hffff_fffc;
    s.imm      = $random(seed);
    s.raddr1   = rand_below(32);
    s.raddr2   = rand_below(32);
    s.src1_sel = isa_pkg::src_sel_e'(rand_below(4));
    s.src2_sel = isa_pkg::src_sel_e'(rand_below(4));
    s.alu_op   = isa_pkg::alu_op_e'(rand_below(11));
    if (rand_below(4) == 0)
      s.br_type = isa_pkg::br_type_e'(1 + rand_below(7));
    s.br_pred  = rand_below(2);
    s.rf_we    = rand_below(4) != 0;
    s.rf_waddr = rand_below(32);
  endtask

  // Address is r0 plus immediate, data comes from raddr2
  task automatic make_mem(inout pipe_pkg::issue_slot_t s, input isa_pkg::mem_type_e t,
                          input int addr);
    s.src1_sel = isa_pkg::src_reg;
    s.raddr1   = 5'd0;
    s.src2_sel = isa_pkg::src_imm;
    s.alu_op   = isa_pkg::alu_add;
    s.imm      = addr;
    s.br_type  = isa_pkg::br_none;
    s.br_pred  = 1'b0;
    s.mem_type = t;
    if (t inside {isa_pkg::mem_st_w, isa_pkg::mem_st_b, isa_pkg::mem_st_h})
      s.rf_we = 1'b0;
  endtask

  task automatic write_mem(input isa_pkg::mem_type_e t, input int adr, input logic [31:0] d);
    mem_model[adr] = d[7:0];
    if (t != isa_pkg::mem_st_b)
      mem_model[adr+1] = d[15:8];
    if (t == isa_pkg::mem_st_w) begin
      mem_model[adr+2] = d[23:16];
      mem_model[adr+3] = d[31:24];
    end
  endtask

  task automatic run_cycle(input pipe_pkg::issue_slot_t a_in, input pipe_pkg::issue_slot_t b_in);
    pipe_pkg::issue_slot_t a;
    pipe_pkg::issue_slot_t b;
    pipe_pkg::wb_slot_t    wa;
    pipe_pkg::wb_slot_t    wbe;
    logic [31:0]           a1;
    logic [31:0]           a2;
    logic [31:0]           b1;
    logic [31:0]           b2;
    logic [31:0]           res_a;
    logic [31:0]           res_b;
    logic [31:0]           tgt_a;
    logic [31:0]           tgt_b;
    logic [31:0]           ld_val;
    logic                  tk_a;
    logic                  tk_b;
    logic                  mis_a;
    logic                  mis_b;
    int                    adr;
    a = a_in;
    b = b_in;
    while (hist_a.size() > 2) begin                 // Retire writes issued 3 cycles ago
      wa  = hist_a.pop_front();
      wbe = hist_b.pop_front();
      if (wa.we && wa.waddr != 0)
        stale_rf[wa.waddr] = wa.wdata;
      if (wbe.we && wbe.waddr != 0)
        stale_rf[wbe.waddr] = wbe.wdata;
    end
    if (load_prev) begin                            // No load use in the next cycle
      if (a.raddr1 == load_rd) a.raddr1 = 0;
      if (a.raddr2 == load_rd) a.raddr2 = 0;
      if (b.raddr1 == load_rd) b.raddr1 = 0;
      if (b.raddr2 == load_rd) b.raddr2 = 0;
    end
    if (a.rf_we) begin                              // No dependency inside a pair
      if (b.raddr1 == a.rf_waddr) b.raddr1 = 0;
      if (b.raddr2 == a.rf_waddr) b.raddr2 = 0;
    end
    a.rdata1 = stale_rf[a.raddr1];
    a.rdata2 = stale_rf[a.raddr2];
    b.rdata1 = stale_rf[b.raddr1];
    b.rdata2 = stale_rf[b.raddr2];
    a1 = arch_rf[a.raddr1];
    a2 = arch_rf[a.raddr2];
    b1 = arch_rf[b.raddr1];
    b2 = arch_rf[b.raddr2];
    res_a = alu_model(a.alu_op, pick_operand(a.src1_sel, a1, a.pc, a.imm),
                      pick_operand(a.src2_sel, a2, a.pc, a.imm));
    res_b = alu_model(b.alu_op, pick_operand(b.src1_sel, b1, b.pc, b.imm),
                      pick_operand(b.src2_sel, b2, b.pc, b.imm));
    tk_a  = taken_model(a.br_type, a1, a2);
    tk_b  = taken_model(b.br_type, b1, b2);
    mis_a = (tk_a != a.br_pred) || (tk_a && a.br_pred);   // Predicted taken still redirects
    mis_b = (tk_b != b.br_pred) || (tk_b && b.br_pred);
    tgt_a = tk_a ? a.pc + a.imm : a.pc + 32'd4;
    tgt_b = tk_b ? b.pc + b.imm : b.pc + 32'd4;
    adr = res_b[5:0];
    ld_val = res_b;
    case (b.mem_type)
      isa_pkg::mem_ld_w:  ld_val = {mem_model[adr+3], mem_model[adr+2],
                                    mem_model[adr+1], mem_model[adr]};
      isa_pkg::mem_ld_b:  ld_val = {{24{mem_model[adr][7]}}, mem_model[adr]};
      isa_pkg::mem_ld_bu: ld_val = {24'd0, mem_model[adr]};
      isa_pkg::mem_ld_h:  ld_val = {{16{mem_model[adr+1][7]}}, mem_model[adr+1], mem_model[adr]};
      default: ;
    endcase
    if (a.mem_type inside {isa_pkg::mem_st_w, isa_pkg::mem_st_b, isa_pkg::mem_st_h})
      write_mem(a.mem_type, res_a[5:0], a2);
    if (!mis_a && b.mem_type inside {isa_pkg::mem_st_w, isa_pkg::mem_st_b, isa_pkg::mem_st_h})
      write_mem(b.mem_type, res_b[5:0], b2);
    wa.we     = a.rf_we;
    wa.waddr  = a.rf_waddr;
    wa.wdata  = res_a;
    wbe.we    = b.rf_we && !mis_a;
    wbe.waddr = b.rf_waddr;
    wbe.wdata = ld_val;
    hist_a.push_back(wa);
    hist_b.push_back(wbe);
    exp_a.push_back(wa);
    exp_b.push_back(wbe);
    if (wa.we && wa.waddr != 0)
      arch_rf[wa.waddr] = wa.wdata;
    if (wbe.we && wbe.waddr != 0)
      arch_rf[wbe.waddr] = wbe.wdata;
    load_prev = b.mem_type inside {isa_pkg::mem_ld_w, isa_pkg::mem_ld_b,
                                   isa_pkg::mem_ld_bu, isa_pkg::mem_ld_h};
    load_rd   = b.rf_waddr;
    @(posedge clk);
    slot_a <= a;
    slot_b <= b;
    @(negedge clk);
    check_value("redirect", mis_a | mis_b, redirect);
    if (mis_a | mis_b)
      check_value("redirect_pc", mis_a ? tgt_a : tgt_b, redirect_pc);
    compare_wb("wb_a", exp_a.pop_front(), wb_a);
    compare_wb("wb_b", exp_b.pop_front(), wb_b);
  endtask

  // Watchdog so a stuck run still ends
  initial begin
    #200000;
    $display("Simulation timed out");
    $display("Something failed");
    $fatal(1);
  end

  initial begin
    pipe_pkg::issue_slot_t a;
    pipe_pkg::issue_slot_t b;
    int                    r;
    seed      = 32'heba6cda5;
    errors    = 0;
    reset     = 1'b1;
    slot_a    = '0;
    slot_b    = '0;
    load_prev = 1'b0;
    load_rd   = '0;
    for (int i = 0; i < 32; i++) begin
      arch_rf[i]  = (i == 0) ? 32'd0 : ((i < 8) ? rand_below(4) : $random(seed));
      stale_rf[i] = arch_rf[i];
    end
    repeat (10) begin
      @(posedge clk);
      @(negedge clk);
      check_value("wb_a.we", 1'b0, wb_a.we);
      check_value("wb_b.we", 1'b0, wb_b.we);
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("wb_a.we", 1'b0, wb_a.we);
    check_value("wb_b.we", 1'b0, wb_b.we);
    repeat (2) begin                                // Bubbles already in flight
      exp_a.push_back('0);
      exp_b.push_back('0);
    end
    for (int i = 0; i < 16; i++) begin              // Give every tested word a value
      gen_slot(a);
      gen_slot(b);
      make_mem(a, isa_pkg::mem_st_w, i * 4);
      run_cycle(a, b);
    end
    repeat (600) begin
      gen_slot(a);
      gen_slot(b);
      r = rand_below(8);
      case (r)
        0: make_mem(a, isa_pkg::mem_st_b, rand_below(64));
        1: make_mem(b, isa_pkg::mem_st_h, rand_below(32) * 2);
        2: begin
          if (rand_below(2))
            make_mem(a, isa_pkg::mem_st_w, rand_below(16) * 4);
          else
            make_mem(b, isa_pkg::mem_st_w, rand_below(16) * 4);
        end
        3: make_mem(b, isa_pkg::mem_ld_w, rand_below(16) * 4);
        4: make_mem(b, isa_pkg::mem_ld_h, rand_below(32) * 2);
        5: make_mem(b, rand_below(2) ? isa_pkg::mem_ld_b : isa_pkg::mem_ld_bu, rand_below(64));
        default: ;
      endcase
      run_cycle(a, b);
    end
    repeat (2) run_cycle('0, '0);                   // Drain the pipeline
    if (errors == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule

// File: ex_mem_wb.f
+incdir+.
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/operand_forward.sv
logic/dual_alu.sv
logic/branch_resolve.sv
logic/store_align.sv
logic/data_memory.sv
logic/exec_pipe_regs.sv
logic/ex_mem_wb.sv
sim/clock_gen.sv
sim/tb_ex_mem_wb.sv
